// File: compile.f
+incdir+rtl
+incdir+test
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/instr_decoder.sv
rtl/perf_counter.sv
rtl/decode_stage.sv
test/tb_decode_stage.sv

// File: rtl/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Threads per warp, sets the thread mask width
`define NUM_THREADS 4

// Warps per core
`define NUM_WARPS 4

`define WID_BITS $clog2(`NUM_WARPS)  // Warp id width

// Width of each performance event counter
`define PERF_CTR_BITS 32

`define UUID_BITS 16  // Instruction uuid width

`endif

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module decode_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fetch_valid,
    input  pipe_pkg::fetch_rsp_t      fetch_rsp,
    output logic                      fetch_ready,
    output logic                      dec_valid,
    output pipe_pkg::decoded_t        dec,
    input  logic                      dec_ready,
    output logic                      wstall_valid,
    output pipe_pkg::wstall_t         wstall,
    output logic                      join_valid,
    output logic [`WID_BITS-1:0]      join_wid,
    output logic [`PERF_CTR_BITS-1:0] perf_loads,
    output logic [`PERF_CTR_BITS-1:0] perf_stores,
    output logic [`PERF_CTR_BITS-1:0] perf_branches
);
    import pipe_pkg::*;

    logic                       fire;
    logic                       is_wstall;
    logic                       is_join;
    logic [NUM_PERF_EVENTS-1:0] perf_hit;
    logic [`PERF_CTR_BITS-1:0]  perf_count [NUM_PERF_EVENTS];

    instr_decoder decoder_inst (
        .fetch     (fetch_rsp),
        .dec       (dec),
        .is_wstall (is_wstall),
        .is_join   (is_join),
        .perf_hit  (perf_hit)
    );

    // No buffering, ready and valid pass straight through
    assign fetch_ready = dec_ready;
    assign dec_valid   = fetch_valid;
    assign fire        = fetch_valid && dec_ready;

    assign wstall_valid = fire;  // Scheduler hears about every issued instruction
    assign wstall       = '{wid: fetch_rsp.wid, stalled: is_wstall};

    assign join_valid = fire && is_join;
    assign join_wid   = fetch_rsp.wid;

    for (genvar ev = 0; ev < NUM_PERF_EVENTS; ev++) begin : g_perf
        perf_counter perf_counter_inst (
            .clk   (clk),
            .reset (reset),
            .fire  (fire),
            .hit   (perf_hit[ev]),
            .tmask (fetch_rsp.tmask),
            .count (perf_count[ev])
        );
    end

    assign perf_loads    = perf_count[EV_LOAD];
    assign perf_stores   = perf_count[EV_STORE];
    assign perf_branches = perf_count[EV_BRANCH];

    // A join never also parks the warp
    join_not_stalled: assert property (
        @(posedge clk) disable iff (reset)
        join_valid |-> !wstall.stalled
    ) else $error("decode_stage: JOIN flagged as a stalling instruction");

endmodule

`default_nettype wire

// File: rtl/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  pipe_pkg::fetch_rsp_t                fetch,
    output pipe_pkg::decoded_t                  dec,
    output logic                                is_wstall,
    output logic                                is_join,
    output logic [pipe_pkg::NUM_PERF_EVENTS-1:0] perf_hit
);
    import isa_pkg::*;
    import pipe_pkg::*;

    instr_t      instr;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [11:0] i_imm;
    logic [11:0] s_imm;
    logic [11:0] alu_imm;
    logic [12:0] b_imm;
    logic [20:0] j_imm;

    ex_type_e    ex_type;
    op_type_t    op_type;
    op_mod_t     op_mod;
    reg_num_t    rd;
    reg_num_t    rs1;
    reg_num_t    rs2;
    logic [31:0] imm;
    logic        use_rd;
    logic        use_pc;
    logic        use_imm;
    logic        stall_op;
    logic        join_op;
    logic        illegal;

    assign instr  = fetch.instr;
    assign opcode = instr.r_fmt.opcode;
    assign funct3 = instr.r_fmt.funct3;
    assign i_imm  = instr.i_fmt.imm12;
    assign s_imm  = {instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
    assign b_imm  = {instr.s_fmt.imm_hi[6], instr.s_fmt.imm_lo[0],
                     instr.s_fmt.imm_hi[5:0], instr.s_fmt.imm_lo[4:1], 1'b0};
    assign j_imm  = {instr.u_fmt.imm20[19], instr.u_fmt.imm20[7:0],
                     instr.u_fmt.imm20[8], instr.u_fmt.imm20[18:9], 1'b0};

    // Shift amounts are a plain 5-bit field
    assign alu_imm = (funct3[0] && !funct3[1]) ? {7'b0, instr.r_fmt.rs2} : i_imm;

    always_comb begin
        ex_type  = EX_NOP;
        op_type  = '0;
        op_mod   = MOD_PLAIN;
        rd       = '0;
        rs1      = '0;
        rs2      = '0;
        imm      = '0;
        use_rd   = 1'b0;
        use_pc   = 1'b0;
        use_imm  = 1'b0;
        stall_op = 1'b0;
        join_op  = 1'b0;
        illegal  = 1'b0;

        case (opcode)
            OPC_I, OPC_R: begin
                ex_type = EX_ALU;
                case (funct3)
                    3'h0: op_type = (opcode == OPC_R && instr.r_fmt.funct7[5]) ?
                                    OP_ALU_SUB : OP_ALU_ADD;
                    3'h5: op_type = instr.r_fmt.funct7[5] ? OP_ALU_SRA : OP_ALU_SRL;
                    default: op_type = op_type_t'(funct3);
                endcase
                use_rd = 1'b1;
                rd     = instr.r_fmt.rd;
                rs1    = instr.r_fmt.rs1;
                if (opcode == OPC_I) begin
                    use_imm = 1'b1;
                    imm     = {{20{alu_imm[11]}}, alu_imm};
                end else begin
                    rs2 = instr.r_fmt.rs2;
                end
            end
            OPC_LUI, OPC_AUIPC: begin
                ex_type = EX_ALU;
                op_type = (opcode == OPC_LUI) ? OP_ALU_LUI : OP_ALU_AUIPC;
                use_rd  = 1'b1;
                use_imm = 1'b1;
                use_pc  = (opcode == OPC_AUIPC);
                rd      = instr.u_fmt.rd;
                imm     = {instr.u_fmt.imm20, 12'b0};
            end
            OPC_JAL: begin
                ex_type  = EX_ALU;
                op_type  = OP_BR_JAL;
                op_mod   = MOD_BRANCH;
                use_rd   = 1'b1;
                use_imm  = 1'b1;
                use_pc   = 1'b1;
                stall_op = 1'b1;
                rd       = instr.u_fmt.rd;
                imm      = {{11{j_imm[20]}}, j_imm};
            end
            OPC_JALR: begin
                ex_type  = EX_ALU;
                op_type  = OP_BR_JALR;
                op_mod   = MOD_BRANCH;
                use_rd   = 1'b1;
                use_imm  = 1'b1;
                stall_op = 1'b1;
                rd       = instr.i_fmt.rd;
                rs1      = instr.i_fmt.rs1;
                imm      = {{20{i_imm[11]}}, i_imm};
            end
            OPC_B: begin
                ex_type  = EX_ALU;
                op_type  = op_type_t'(funct3);  // Branch codes follow funct3
                op_mod   = MOD_BRANCH;
                use_imm  = 1'b1;
                use_pc   = 1'b1;
                stall_op = 1'b1;
                rs1      = instr.s_fmt.rs1;
                rs2      = instr.s_fmt.rs2;
                imm      = {{19{b_imm[12]}}, b_imm};
                illegal  = (funct3[2:1] == 2'b01);
            end
            OPC_FENCE: begin
                ex_type = EX_LSU;
                op_mod  = MOD_FENCE;
            end
            OPC_SYS: begin
                if (funct3[1:0] != 2'b00) begin
                    ex_type = EX_CSR;
                    op_type = op_type_t'(funct3[1:0]);
                    use_rd  = 1'b1;
                    use_imm = funct3[2];
                    rd      = instr.i_fmt.rd;
                    rs1     = instr.i_fmt.rs1;  // Register or uimm
                    imm     = {15'b0, funct3[2] ? instr.i_fmt.rs1 : 5'b0, i_imm};
                end else if (funct3 == 3'h0) begin
                    ex_type  = EX_ALU;
                    op_mod   = MOD_BRANCH;
                    use_rd   = 1'b1;
                    use_imm  = 1'b1;
                    use_pc   = 1'b1;
                    stall_op = 1'b1;
                    rd       = instr.i_fmt.rd;
                    imm      = 32'd4;
                    case (i_imm)
                        12'h000: op_type = OP_BR_ECALL;
                        12'h001: op_type = OP_BR_EBREAK;
                        12'h002: op_type = OP_BR_URET;
                        12'h102: op_type = OP_BR_SRET;
                        12'h302: op_type = OP_BR_MRET;
                        default: illegal = 1'b1;
                    endcase
                end else begin
                    illegal = 1'b1;
                end
            end
            OPC_L: begin
                ex_type = EX_LSU;
                op_type = {1'b0, funct3};
                use_rd  = 1'b1;
                rd      = instr.i_fmt.rd;
                rs1     = instr.i_fmt.rs1;
                imm     = {{20{i_imm[11]}}, i_imm};
            end
            OPC_S: begin
                ex_type = EX_LSU;
                op_type = {1'b1, funct3};
                rs1     = instr.s_fmt.rs1;
                rs2     = instr.s_fmt.rs2;
                imm     = {{20{s_imm[11]}}, s_imm};
            end
            OPC_GPGPU: begin
                ex_type = EX_GPU;
                rs1     = instr.r_fmt.rs1;
                case (funct3)
                    3'h0: begin
                        op_type  = instr.r_fmt.rs2[0] ? OP_GPU_PRED : OP_GPU_TMC;
                        stall_op = 1'b1;
                    end
                    3'h1: begin
                        op_type = OP_GPU_WSPAWN;
                        rs2     = instr.r_fmt.rs2;
                    end
                    3'h2: begin
                        op_type  = OP_GPU_SPLIT;
                        stall_op = 1'b1;
                    end
                    3'h3: begin
                        op_type = OP_GPU_JOIN;
                        rs1     = '0;  // JOIN reads no register
                        join_op = 1'b1;
                    end
                    3'h4: begin
                        op_type  = OP_GPU_BAR;
                        rs2      = instr.r_fmt.rs2;
                        stall_op = 1'b1;
                    end
                    3'h5: begin
                        ex_type = EX_LSU;
                        op_type = OP_LSU_LW;
                        op_mod  = MOD_LOCAL;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            default: illegal = 1'b1;
        endcase

        // Undefined encodings leave the record empty
        if (illegal) begin
            ex_type  = EX_NOP;
            op_type  = '0;
            op_mod   = MOD_PLAIN;
            rd       = '0;
            rs1      = '0;
            rs2      = '0;
            imm      = '0;
            use_rd   = 1'b0;
            use_pc   = 1'b0;
            use_imm  = 1'b0;
            stall_op = 1'b0;
            join_op  = 1'b0;
        end
    end

    always_comb begin
        dec.uuid    = fetch.uuid;
        dec.wid     = fetch.wid;
        dec.tmask   = fetch.tmask;
        dec.pc      = fetch.pc;
        dec.ex_type = ex_type;
        dec.op_type = op_type;
        dec.op_mod  = op_mod;
        dec.wb      = use_rd && (rd != '0);  // x0 is never written
        dec.rd      = rd;
        dec.rs1     = rs1;
        dec.rs2     = rs2;
        dec.imm     = imm;
        dec.use_pc  = use_pc;
        dec.use_imm = use_imm;
    end

    assign is_wstall = stall_op;
    assign is_join   = join_op;

    assign perf_hit[EV_LOAD]   = (opcode == OPC_L);
    assign perf_hit[EV_STORE]  = (opcode == OPC_S);
    assign perf_hit[EV_BRANCH] = (ex_type == EX_ALU) && (op_mod == MOD_BRANCH);

    // Event classes never overlap
    always_comb begin
        assert final ($onehot0(perf_hit))
            else $error("instr_decoder: several perf events for one instruction");
    end

endmodule

`default_nettype wire

// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [4:0] reg_num_t;
    typedef logic [3:0] op_type_t;
    typedef logic [2:0] op_mod_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_num_t   rs2;
        reg_num_t   rs1;
        logic [2:0] funct3;
        reg_num_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_num_t    rs1;
        logic [2:0]  funct3;
        reg_num_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_num_t   rs2;
        reg_num_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        reg_num_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // One instruction word, B and J layouts are rebuilt from s and u
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
    } instr_t;

    localparam logic [6:0] OPC_I     = 7'h13;
    localparam logic [6:0] OPC_R     = 7'h33;
    localparam logic [6:0] OPC_LUI   = 7'h37;
    localparam logic [6:0] OPC_AUIPC = 7'h17;
    localparam logic [6:0] OPC_JAL   = 7'h6F;
    localparam logic [6:0] OPC_JALR  = 7'h67;
    localparam logic [6:0] OPC_B     = 7'h63;
    localparam logic [6:0] OPC_FENCE = 7'h0F;
    localparam logic [6:0] OPC_SYS   = 7'h73;
    localparam logic [6:0] OPC_L     = 7'h03;
    localparam logic [6:0] OPC_S     = 7'h23;
    localparam logic [6:0] OPC_GPGPU = 7'h6B;  // Warp control group

    typedef enum logic [2:0] {
        EX_NOP = 3'd0,
        EX_ALU = 3'd1,
        EX_LSU = 3'd2,
        EX_CSR = 3'd3,
        EX_GPU = 3'd4
    } ex_type_e;

    // ALU ops, first eight in funct3 order
    localparam op_type_t OP_ALU_ADD   = 4'd0;
    localparam op_type_t OP_ALU_SLL   = 4'd1;
    localparam op_type_t OP_ALU_SLT   = 4'd2;
    localparam op_type_t OP_ALU_SLTU  = 4'd3;
    localparam op_type_t OP_ALU_XOR   = 4'd4;
    localparam op_type_t OP_ALU_SRL   = 4'd5;
    localparam op_type_t OP_ALU_OR    = 4'd6;
    localparam op_type_t OP_ALU_AND   = 4'd7;
    localparam op_type_t OP_ALU_SUB   = 4'd8;
    localparam op_type_t OP_ALU_SRA   = 4'd9;
    localparam op_type_t OP_ALU_LUI   = 4'd10;
    localparam op_type_t OP_ALU_AUIPC = 4'd11;

    localparam op_type_t OP_BR_EQ     = 4'd0;
    localparam op_type_t OP_BR_NE     = 4'd1;
    localparam op_type_t OP_BR_LT     = 4'd4;
    localparam op_type_t OP_BR_GE     = 4'd5;
    localparam op_type_t OP_BR_LTU    = 4'd6;
    localparam op_type_t OP_BR_GEU    = 4'd7;
    localparam op_type_t OP_BR_JAL    = 4'd8;
    localparam op_type_t OP_BR_JALR   = 4'd9;
    localparam op_type_t OP_BR_ECALL  = 4'd10;
    localparam op_type_t OP_BR_EBREAK = 4'd11;
    localparam op_type_t OP_BR_URET   = 4'd12;
    localparam op_type_t OP_BR_SRET   = 4'd13;
    localparam op_type_t OP_BR_MRET   = 4'd14;

    localparam op_type_t OP_GPU_TMC    = 4'd0;
    localparam op_type_t OP_GPU_WSPAWN = 4'd1;
    localparam op_type_t OP_GPU_SPLIT  = 4'd2;
    localparam op_type_t OP_GPU_JOIN   = 4'd3;
    localparam op_type_t OP_GPU_BAR    = 4'd4;
    localparam op_type_t OP_GPU_PRED   = 4'd5;

    localparam op_type_t OP_LSU_LW = 4'd2;  // Word load, funct3 of LW

    localparam op_mod_t MOD_PLAIN  = 3'd0;
    localparam op_mod_t MOD_BRANCH = 3'd1;
    localparam op_mod_t MOD_FENCE  = 3'd1;  // LSU only
    localparam op_mod_t MOD_LOCAL  = 3'd2;  // Warp-local load

endpackage

`default_nettype wire

// File: rtl/perf_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module perf_counter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fire,
    input  logic                      hit,
    input  pipe_pkg::tmask_t          tmask,
    output logic [`PERF_CTR_BITS-1:0] count
);
    localparam int CNT_BITS = $clog2(`NUM_THREADS + 1);

    logic [CNT_BITS-1:0] active;  // Threads taking part this cycle

    always_comb begin
        active = '0;
        for (int i = 0; i < `NUM_THREADS; i++) begin
            active = active + CNT_BITS'(tmask[i]);
        end
    end

    // Wraps at full scale
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (fire && hit) begin
            count <= count + `PERF_CTR_BITS'(active);
        end
    end

    // A new count is only ever the result of a counted fire
    count_after_fire: assert property (
        @(posedge clk) disable iff (reset)
        (!$past(reset) && (count != $past(count))) |-> $past(fire && hit)
    ) else $error("perf_counter: count moved without a counted fire");

endmodule

`default_nettype wire

// File: rtl/pipe_pkg.sv
`default_nettype none

`include "decode_settings.svh"

package pipe_pkg;
    import isa_pkg::*;

    localparam int NUM_PERF_EVENTS = 3;

    typedef logic [`NUM_THREADS-1:0] tmask_t;

    // Fetch to decode
    typedef struct packed {
        logic [`UUID_BITS-1:0] uuid;
        logic [`WID_BITS-1:0]  wid;
        tmask_t                tmask;
        logic [31:0]           pc;
        instr_t                instr;
    } fetch_rsp_t;

    // Decode to issue
    typedef struct packed {
        logic [`UUID_BITS-1:0] uuid;
        logic [`WID_BITS-1:0]  wid;
        tmask_t                tmask;
        logic [31:0]           pc;
        ex_type_e              ex_type;
        op_type_t              op_type;
        op_mod_t               op_mod;
        logic                  wb;
        reg_num_t              rd;
        reg_num_t              rs1;
        reg_num_t              rs2;
        logic [31:0]           imm;
        logic                  use_pc;
        logic                  use_imm;
    } decoded_t;

    typedef struct packed {
        logic [`WID_BITS-1:0] wid;
        logic                 stalled;
    } wstall_t;

    typedef enum logic [1:0] {
        EV_LOAD   = 2'd0,
        EV_STORE  = 2'd1,
        EV_BRANCH = 2'd2
    } perf_event_e;

endpackage

`default_nettype wire

// File: test/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expected decode of one fetched instruction, worked from the raw word
function automatic void decode_ref(input fetch_rsp_t f, output decoded_t d,
                                   output logic stalled, output logic joins);
    logic [31:0] w;
    logic [2:0]  f3;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        writes;
    logic        legal;

    w      = f.instr;
    f3     = w[14:12];
    imm_i  = {{20{w[31]}}, w[31:20]};
    imm_s  = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    d      = '0;
    stalled = 1'b0;
    joins  = 1'b0;
    writes = 1'b0;
    legal  = 1'b1;

    case (w[6:0])
        OPC_I: begin
            d.ex_type = EX_ALU;
            d.op_type = (f3 == 3'd5 && w[30]) ? OP_ALU_SRA : {1'b0, f3};
            d.rd      = w[11:7];
            d.rs1     = w[19:15];
            d.use_imm = 1'b1;
            d.imm     = (f3 == 3'd1 || f3 == 3'd5) ? {27'b0, w[24:20]} : imm_i;  // shamt
            writes    = 1'b1;
        end
        OPC_R: begin
            d.ex_type = EX_ALU;
            if (f3 == 3'd0 && w[30])
                d.op_type = OP_ALU_SUB;
            else if (f3 == 3'd5 && w[30])
                d.op_type = OP_ALU_SRA;
            else
                d.op_type = {1'b0, f3};
            d.rd      = w[11:7];
            d.rs1     = w[19:15];
            d.rs2     = w[24:20];
            writes    = 1'b1;
        end
        OPC_LUI, OPC_AUIPC: begin
            d.ex_type = EX_ALU;
            d.op_type = (w[6:0] == OPC_LUI) ? OP_ALU_LUI : OP_ALU_AUIPC;
            d.use_pc  = (w[6:0] == OPC_AUIPC);
            d.use_imm = 1'b1;
            d.rd      = w[11:7];
            d.imm     = {w[31:12], 12'b0};
            writes    = 1'b1;
        end
        OPC_JAL, OPC_JALR: begin
            d.ex_type = EX_ALU;
            d.op_mod  = MOD_BRANCH;
            d.use_imm = 1'b1;
            d.rd      = w[11:7];
            writes    = 1'b1;
            stalled   = 1'b1;
            if (w[6:0] == OPC_JAL) begin
                d.op_type = OP_BR_JAL;
                d.use_pc  = 1'b1;
                d.imm     = imm_j;
            end else begin
                d.op_type = OP_BR_JALR;
                d.rs1     = w[19:15];
                d.imm     = imm_i;
            end
        end
        OPC_B: begin
            legal     = (f3 != 3'd2) && (f3 != 3'd3);
            d.ex_type = EX_ALU;
            d.op_type = {1'b0, f3};
            d.op_mod  = MOD_BRANCH;
            d.rs1     = w[19:15];
            d.rs2     = w[24:20];
            d.use_pc  = 1'b1;
            d.use_imm = 1'b1;
            d.imm     = imm_b;
            stalled   = 1'b1;
        end
        OPC_FENCE: begin
            d.ex_type = EX_LSU;
            d.op_mod  = MOD_FENCE;
        end
        OPC_SYS: begin
            if (f3 == 3'd0) begin
                d.ex_type = EX_ALU;
                d.op_mod  = MOD_BRANCH;
                d.rd      = w[11:7];
                d.use_pc  = 1'b1;
                d.use_imm = 1'b1;
                d.imm     = 32'd4;  // Return address offset
                writes    = 1'b1;
                stalled   = 1'b1;
                case (w[31:20])
                    12'h000: d.op_type = OP_BR_ECALL;
                    12'h001: d.op_type = OP_BR_EBREAK;
                    12'h002: d.op_type = OP_BR_URET;
                    12'h102: d.op_type = OP_BR_SRET;
                    12'h302: d.op_type = OP_BR_MRET;
                    default: legal = 1'b0;
                endcase
            end else if (f3 == 3'd4) begin
                legal = 1'b0;
            end else begin
                d.ex_type = EX_CSR;
                d.op_type = {2'b0, f3[1:0]};
                d.rd      = w[11:7];
                d.rs1     = w[19:15];
                d.use_imm = f3[2];
                d.imm     = f3[2] ? {15'b0, w[19:15], w[31:20]} : {20'b0, w[31:20]};
                writes    = 1'b1;
            end
        end
        OPC_L: begin
            d.ex_type = EX_LSU;
            d.op_type = {1'b0, f3};
            d.rd      = w[11:7];
            d.rs1     = w[19:15];
            d.imm     = imm_i;
            writes    = 1'b1;
        end
        OPC_S: begin
            d.ex_type = EX_LSU;
            d.op_type = {1'b1, f3};
            d.rs1     = w[19:15];
            d.rs2     = w[24:20];
            d.imm     = imm_s;
        end
        OPC_GPGPU: begin
            d.ex_type = EX_GPU;
            d.rs1     = w[19:15];
            case (f3)
                3'd0: begin
                    d.op_type = w[20] ? OP_GPU_PRED : OP_GPU_TMC;
                    stalled   = 1'b1;
                end
                3'd1: begin
                    d.op_type = OP_GPU_WSPAWN;
                    d.rs2     = w[24:20];
                end
                3'd2: begin
                    d.op_type = OP_GPU_SPLIT;
                    stalled   = 1'b1;
                end
                3'd3: begin
                    d.op_type = OP_GPU_JOIN;
                    d.rs1     = '0;
                    joins     = 1'b1;
                end
                3'd4: begin
                    d.op_type = OP_GPU_BAR;
                    d.rs2     = w[24:20];
                    stalled   = 1'b1;
                end
                3'd5: begin
                    d.ex_type = EX_LSU;  // Warp-local LW
                    d.op_type = OP_LSU_LW;
                    d.op_mod  = MOD_LOCAL;
                end
                default: legal = 1'b0;
            endcase
        end
        default: legal = 1'b0;
    endcase

    if (!legal) begin
        d       = '0;
        stalled = 1'b0;
        joins   = 1'b0;
        writes  = 1'b0;
    end
    d.wb    = writes && (d.rd != 5'd0);
    d.uuid  = f.uuid;
    d.wid   = f.wid;
    d.tmask = f.tmask;
    d.pc    = f.pc;
endfunction

function automatic int count_active(input tmask_t m);
    int n;

    n = 0;
    for (int i = 0; i < `NUM_THREADS; i++) begin
        n += m[i];
    end
    return n;
endfunction

`endif

// File: test/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module tb_decode_stage;
    import isa_pkg::*;
    import pipe_pkg::*;

    `include "decode_model.svh"

    localparam int NUM_TXNS   = 2000;
    localparam int MAX_CYCLES = 2 * NUM_TXNS + 100;

    logic                      clk;
    logic                      reset;
    logic                      fetch_valid;
    fetch_rsp_t                fetch_rsp;
    logic                      fetch_ready;
    logic                      dec_valid;
    decoded_t                  dec;
    logic                      dec_ready;
    logic                      wstall_valid;
    wstall_t                   wstall;
    logic                      join_valid;
    logic [`WID_BITS-1:0]      join_wid;
    logic [`PERF_CTR_BITS-1:0] perf_loads;
    logic [`PERF_CTR_BITS-1:0] perf_stores;
    logic [`PERF_CTR_BITS-1:0] perf_branches;

    // Reference state
    decoded_t                  exp_dec;
    wstall_t                   exp_wstall;
    logic                      exp_stall;
    logic                      exp_join;
    logic                      fire;
    logic [`PERF_CTR_BITS-1:0] sum_loads;
    logic [`PERF_CTR_BITS-1:0] sum_stores;
    logic [`PERF_CTR_BITS-1:0] sum_branches;
    int                        cycle_count;

    decode_stage decode_stage_inst (
        .clk           (clk),
        .reset         (reset),
        .fetch_valid   (fetch_valid),
        .fetch_rsp     (fetch_rsp),
        .fetch_ready   (fetch_ready),
        .dec_valid     (dec_valid),
        .dec           (dec),
        .dec_ready     (dec_ready),
        .wstall_valid  (wstall_valid),
        .wstall        (wstall),
        .join_valid    (join_valid),
        .join_wid      (join_wid),
        .perf_loads    (perf_loads),
        .perf_stores   (perf_stores),
        .perf_branches (perf_branches)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_decoded(input string name, input decoded_t got, input decoded_t exp);
        if (got !== exp) begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_wstall(input string name, input wstall_t got, input wstall_t exp);
        if (got !== exp) begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_count(input string name, input logic [`PERF_CTR_BITS-1:0] got,
                                 input logic [`PERF_CTR_BITS-1:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_wid(input string name, input logic [`WID_BITS-1:0] got,
                               input logic [`WID_BITS-1:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // Mostly kept opcodes, some stray ones for the NOP path
    function automatic logic [31:0] random_instr();
        logic [31:0] w;
        logic [6:0]  opc;

        w = $urandom();
        case ($urandom_range(11))
            0:       opc = OPC_I;
            1:       opc = OPC_R;
            2:       opc = OPC_LUI;
            3:       opc = OPC_AUIPC;
            4:       opc = OPC_JAL;
            5:       opc = OPC_JALR;
            6:       opc = OPC_B;
            7:       opc = OPC_FENCE;
            8:       opc = OPC_SYS;
            9:       opc = OPC_L;
            10:      opc = OPC_S;
            default: opc = OPC_GPGPU;
        endcase
        if ($urandom_range(9) == 0)
            opc = 7'($urandom());
        if (opc == OPC_SYS && $urandom_range(2) == 0) begin
            w[14:12] = 3'd0;
            case ($urandom_range(5))
                0: w[31:20] = 12'h000;
                1: w[31:20] = 12'h001;
                2: w[31:20] = 12'h002;
                3: w[31:20] = 12'h102;
                4: w[31:20] = 12'h302;
                default: ;  // Leave a random system code
            endcase
        end
        if ($urandom_range(7) == 0)
            w[11:7] = 5'd0;
        w[6:0] = opc;
        return w;
    endfunction

    initial begin
        fetch_rsp_t  nxt;
        logic [31:0] rnd;
        int          txn;

        void'($urandom(32'hf689));
        reset       <= 1'b1;
        fetch_valid <= 1'b0;
        dec_ready   <= 1'b0;
        fetch_rsp   <= '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        txn = 0;
        while (txn < NUM_TXNS) begin
            @(posedge clk);
            if (fetch_valid && dec_ready)
                txn++;
            if (txn < NUM_TXNS) begin
                if (!fetch_valid || dec_ready) begin  // Slot free, else hold
                    rnd         = $urandom();
                    nxt.uuid    = rnd[`UUID_BITS-1:0];
                    nxt.wid     = rnd[`UUID_BITS +: `WID_BITS];
                    nxt.tmask   = rnd[31 -: `NUM_THREADS];
                    nxt.pc      = $urandom() & 32'hFFFF_FFFC;
                    nxt.instr   = random_instr();
                    fetch_rsp   <= nxt;
                    fetch_valid <= ($urandom_range(9) != 0);
                end
                dec_ready <= ($urandom_range(9) >= 3);
            end else begin
                fetch_valid <= 1'b0;
            end
        end

        repeat (2) @(negedge clk);  // Last fire reaches the counters
        @(posedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

    always @(negedge clk) begin
        if (reset) begin
            sum_loads    = '0;
            sum_stores   = '0;
            sum_branches = '0;
        end else begin
            compare_bit("fetch_ready", fetch_ready, dec_ready);
            compare_bit("dec_valid", dec_valid, fetch_valid);

            decode_ref(fetch_rsp, exp_dec, exp_stall, exp_join);
            compare_decoded("dec", dec, exp_dec);

            fire = fetch_valid && dec_ready;
            compare_bit("wstall_valid", wstall_valid, fire);
            if (fire) begin
                exp_wstall.wid     = fetch_rsp.wid;
                exp_wstall.stalled = exp_stall;
                compare_wstall("wstall", wstall, exp_wstall);
            end
            compare_bit("join_valid", join_valid, fire && exp_join);
            if (fire && exp_join)
                compare_wid("join_wid", join_wid, fetch_rsp.wid);

            // Counters hold every fire before this cycle
            compare_count("perf_loads", perf_loads, sum_loads);
            compare_count("perf_stores", perf_stores, sum_stores);
            compare_count("perf_branches", perf_branches, sum_branches);

            if (fire) begin
                if (fetch_rsp.instr.r_fmt.opcode == OPC_L)
                    sum_loads = sum_loads + count_active(fetch_rsp.tmask);
                if (fetch_rsp.instr.r_fmt.opcode == OPC_S)
                    sum_stores = sum_stores + count_active(fetch_rsp.tmask);
                if (exp_dec.ex_type == EX_ALU && exp_dec.op_mod == MOD_BRANCH)
                    sum_branches = sum_branches + count_active(fetch_rsp.tmask);
            end
        end
    end

    initial cycle_count = 0;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the random run did not finish in %0d cycles", MAX_CYCLES);
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire
